// ==== rtl/uart_tx_pkg.sv ====
// shared constants and byte type for the UART transmit subsystem, imported by RTL and testbench
`default_nettype none

package uart_tx_pkg;

	// system clock and line rate
	localparam int CLK_FREQ_HZ = 16_000_000;
	localparam int BAUD_RATE = 1_000_000;

	// clocks per bit
	localparam int CLKS_PER_BIT = CLK_FREQ_HZ / BAUD_RATE;

	// frame layout, start bit + data + stop
	localparam int DATA_BITS = 8;
	localparam int STOP_BITS = 1;
	localparam int FRAME_BITS = 1 + DATA_BITS + STOP_BITS;

	// byte queue between host and transmitter
	localparam int FIFO_DEPTH = 64;

	// occupancy has to reach FIFO_DEPTH itself, so one extra bit
	localparam int FIFO_COUNT_W = $clog2(FIFO_DEPTH + 1);

	// one data byte as carried through the FIFO
	typedef logic [DATA_BITS-1:0] data_t;

endpackage

`default_nettype wire

// ==== rtl/baud_tick_gen.sv ====
// bit-period timer, produces a one-cycle tick every CLKS_PER_BIT clocks while enabled
`default_nettype none

module baud_tick_gen (
	input  wire logic clk,
	input  wire logic reset,
	input  wire logic enable,
	output logic      tick
);

	import uart_tx_pkg::*;

	logic [$clog2(CLKS_PER_BIT)-1:0] cnt;
	logic                            wrap;

	assign wrap = (cnt == CLKS_PER_BIT - 1);

	// counter held at zero when disabled so every bit starts fresh
	always_ff @(posedge clk) begin
		if (reset) begin
			cnt <= '0;
			tick <= 1'b0;
		end else begin
			if (!enable) begin
				cnt <= '0;
			end else if (wrap) begin
				cnt <= '0;
			end else begin
				cnt <= cnt + 1'b1;
			end
			tick <= enable && wrap;
		end
	end

	// a tick needs the generator running for a whole bit period
	a_tick_needs_enable: assert property (
		@(posedge clk) disable iff (reset)
		tick |-> $past(enable) && $past(enable, CLKS_PER_BIT)
	) else $error("tick without a full bit period of enable");

endmodule

`default_nettype wire

// ==== rtl/byte_fifo.sv ====
// circular byte queue with registered read data, feeds the transmit core from the host side
`default_nettype none

module byte_fifo #(
	parameter int DEPTH = uart_tx_pkg::FIFO_DEPTH
) (
	input  wire logic                              clk,
	input  wire logic                              reset,
	input  wire logic                              push,
	input  wire logic                              pop,
	input  wire uart_tx_pkg::data_t                wr_data,
	output uart_tx_pkg::data_t                     rd_data,
	output logic                                   full,
	output logic                                   empty,
	output logic [uart_tx_pkg::FIFO_COUNT_W-1:0]   count
);

	import uart_tx_pkg::*;

	// DEPTH must be a power of two, pointers wrap on overflow
	data_t                  mem [DEPTH];
	logic [$clog2(DEPTH)-1:0] wr_ptr;
	logic [$clog2(DEPTH)-1:0] rd_ptr;
	logic                   wr_en;
	logic                   rd_en;

	assign full = (count == DEPTH);
	assign empty = (count == 0);

	assign wr_en = push && !full;
	assign rd_en = pop && !empty;

	// pointers and occupancy
	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (wr_en) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (rd_en) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({wr_en, rd_en})
				2'b10: begin
					count <= count + 1'b1;
				end
				2'b01: begin
					count <= count - 1'b1;
				end
				default: begin
					count <= count;
				end
			endcase
		end
	end

	// storage and read port, popped byte shows up next cycle
	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_ptr] <= wr_data;
		end
		if (rd_en) begin
			rd_data <= mem[rd_ptr];
		end
	end

	a_no_push_when_full: assert property (
		@(posedge clk) disable iff (reset)
		push |-> !full
	) else $error("push while FIFO full");

	a_no_pop_when_empty: assert property (
		@(posedge clk) disable iff (reset)
		pop |-> !empty
	) else $error("pop while FIFO empty");

endmodule

`default_nettype wire

// ==== rtl/uart_tx_core.sv ====
// UART frame FSM, pulls bytes from the FIFO and shifts start, data and stop bits onto tx
`default_nettype none

module uart_tx_core (
	input  wire logic               clk,
	input  wire logic               reset,
	input  wire logic               new_data,
	input  wire logic               fifo_empty,
	input  wire uart_tx_pkg::data_t fifo_data,
	input  wire logic               tick,
	output logic                    pop,
	output logic                    tick_enable,
	output logic                    tx,
	output logic                    busy
);

	import uart_tx_pkg::*;

	typedef enum logic [1:0] {
		idle,
		fetching,
		transmitting
	} state_t;

	state_t                        state;
	state_t                        state_next;
	logic [$clog2(FRAME_BITS)-1:0] bit_cnt;
	logic [$clog2(FRAME_BITS)-1:0] bit_cnt_next;
	data_t                         shift_reg;
	data_t                         shift_reg_next;
	logic                          tx_next;
	logic                          busy_next;
	logic                          frame_done;

	// tick after the last stop bit closes the frame
	assign frame_done = (state == transmitting) && tick
		&& (bit_cnt == DATA_BITS + STOP_BITS);

	assign pop = (state == idle) && !fifo_empty;
	assign tick_enable = (state == transmitting);

	always_comb begin
		state_next = state;
		bit_cnt_next = bit_cnt;
		shift_reg_next = shift_reg;
		tx_next = tx;
		case (state)
			idle: begin
				tx_next = 1'b1;
				bit_cnt_next = '0;
				// start bit goes out together with the fetch
				if (!fifo_empty) begin
					state_next = fetching;
					tx_next = 1'b0;
				end
			end
			fetching: begin
				shift_reg_next = fifo_data;
				state_next = transmitting;
			end
			transmitting: begin
				if (tick) begin
					bit_cnt_next = bit_cnt + 1'b1;
					if (bit_cnt < DATA_BITS) begin
						// lsb first
						tx_next = shift_reg[0];
						shift_reg_next = {1'b0, shift_reg[DATA_BITS-1:1]};
					end else if (frame_done) begin
						state_next = idle;
						bit_cnt_next = '0;
					end else begin
						tx_next = 1'b1;
					end
				end
			end
			default: begin
				state_next = idle;
				tx_next = 1'b1;
			end
		endcase
	end

	// set on any accepted push, cleared when the last frame drains the queue
	always_comb begin
		busy_next = busy;
		if (new_data) begin
			busy_next = 1'b1;
		end else if (frame_done && fifo_empty) begin
			busy_next = 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= idle;
			bit_cnt <= '0;
			tx <= 1'b1;
			busy <= 1'b0;
		end else begin
			state <= state_next;
			bit_cnt <= bit_cnt_next;
			tx <= tx_next;
			busy <= busy_next;
		end
	end

	always_ff @(posedge clk) begin
		shift_reg <= shift_reg_next;
	end

	a_idle_line_high: assert property (
		@(posedge clk) disable iff (reset)
		(state == idle) |-> tx
	) else $error("tx low while idle");

	// start bit begins in the fetch cycle right after a pop
	a_pop_from_idle: assert property (
		@(posedge clk) disable iff (reset)
		pop |=> (state == fetching) && !tx
	) else $error("pop not followed by fetch with tx low");

endmodule

`default_nettype wire

// ==== rtl/uart_tx_top.sv ====
// UART transmit top level, turns start edges into FIFO pushes and wires FIFO, timer and core
`default_nettype none

module uart_tx_top (
	input  wire logic               clk,
	input  wire logic               reset,
	input  wire logic               start,
	input  wire uart_tx_pkg::data_t data_in,
	output logic                    tx,
	output logic                    busy,
	output logic                    full
);

	import uart_tx_pkg::*;

	logic                    start_q;
	logic                    push;
	logic                    pop;
	logic                    fifo_empty;
	data_t                   fifo_data;
	logic [FIFO_COUNT_W-1:0] fifo_count;
	logic                    tick;
	logic                    tick_enable;

	always_ff @(posedge clk) begin
		if (reset) begin
			start_q <= 1'b0;
		end else begin
			start_q <= start;
		end
	end

	// rising edge of start, dropped when the queue is full
	assign push = start && !start_q && !full;

	byte_fifo u_fifo (
		.clk     (clk),
		.reset   (reset),
		.push    (push),
		.pop     (pop),
		.wr_data (data_in),
		.rd_data (fifo_data),
		.full    (full),
		.empty   (fifo_empty),
		.count   (fifo_count)
	);

	baud_tick_gen u_tick (
		.clk    (clk),
		.reset  (reset),
		.enable (tick_enable),
		.tick   (tick)
	);

	uart_tx_core u_core (
		.clk         (clk),
		.reset       (reset),
		.new_data    (push),
		.fifo_empty  (fifo_empty),
		.fifo_data   (fifo_data),
		.tick        (tick),
		.pop         (pop),
		.tick_enable (tick_enable),
		.tx          (tx),
		.busy        (busy)
	);

	// an edge without a pop in the same cycle grows the queue by one
	a_push_counts: assert property (
		@(posedge clk) disable iff (reset)
		push && !pop |=> fifo_count == $past(fifo_count) + 1'b1
	) else $error("accepted push not reflected in FIFO count");

endmodule

`default_nettype wire

// ==== dv/uart_tx_checks.svh ====
// expected frame builder and typed compare tasks, included inside the UART transmit testbench
`ifndef UART_TX_CHECKS_SVH
`define UART_TX_CHECKS_SVH

// line pattern for one byte, index 0 is the first bit on the wire
function automatic logic [FRAME_BITS-1:0] expected_frame(input data_t value);
	logic [FRAME_BITS-1:0] frame;
	frame[0] = 1'b0;
	for (int i = 0; i < DATA_BITS; i++) begin
		frame[1 + i] = value[i];
	end
	for (int i = 0; i < STOP_BITS; i++) begin
		frame[1 + DATA_BITS + i] = 1'b1;
	end
	return frame;
endfunction

task automatic compare_byte(input string what, input data_t exp, input data_t act);
	if (act !== exp) begin
		$display("Error %s %s: expected %h, actual %h", cur_test, what, exp, act);
		errors++;
	end
endtask

task automatic compare_frame(
	input string                 what,
	input logic [FRAME_BITS-1:0] exp,
	input logic [FRAME_BITS-1:0] act
);
	if (act !== exp) begin
		$display("Error %s %s: expected %b, actual %b", cur_test, what, exp, act);
		errors++;
	end
endtask

// single wire levels such as tx, busy and full
task automatic compare_level(input string what, input logic exp, input logic act);
	if (act !== exp) begin
		$display("Error %s %s: expected %b, actual %b", cur_test, what, exp, act);
		errors++;
	end
endtask

`endif

// ==== dv/uart_tx_tb.sv ====
// testbench for the UART transmit top level, pushes bytes through start edges and checks tx frames
`default_nettype none

module uart_tx_tb;

	import uart_tx_pkg::*;

	localparam int BURST_BYTES = 20;
	localparam int FLOOD_BYTES = 70;
	localparam int FRAME_CYCLES = FRAME_BITS * CLKS_PER_BIT + 8;
	// two single bytes plus the burst and the flood
	localparam longint TOTAL_BYTES = 2 + BURST_BYTES + FLOOD_BYTES;
	localparam longint WATCHDOG_TIME =
		2 * TOTAL_BYTES * FRAME_BITS * CLKS_PER_BIT * 40 + 100_000;

	logic  clk;
	logic  reset;
	logic  start;
	data_t data_in;
	logic  tx;
	logic  busy;
	logic  full;

	string cur_test;
	int    errors;
	int    test_base;
	int    tests_passed;
	int    tests_failed;
	int    seed;
	int    accepted;
	int    frames_started;
	int    frames_done;
	data_t exp_q[$];

	`include "uart_tx_checks.svh"

	uart_tx_top DUT (
		.clk     (clk),
		.reset   (reset),
		.start   (start),
		.data_in (data_in),
		.tx      (tx),
		.busy    (busy),
		.full    (full)
	);

	always #20 clk = ~clk;

	function automatic data_t random_byte();
		logic [31:0] r;
		r = $random(seed);
		return r[DATA_BITS-1:0];
	endfunction

	// raise start with a byte; the model keeps it only if the FIFO has room
	task automatic queue_byte(input data_t value);
		@(negedge clk);
		compare_level("full", (accepted - frames_started) == FIFO_DEPTH, full);
		if (accepted - frames_started < FIFO_DEPTH) begin
			exp_q.push_back(value);
			accepted++;
		end
		data_in = value;
		start = 1'b1;
	endtask

	task automatic push_byte(input data_t value);
		queue_byte(value);
		@(negedge clk);
		start = 1'b0;
	endtask

	task automatic wait_frames(input int target, input logic watch_busy);
		int   waited;
		int   limit;
		logic held;
		waited = 0;
		limit = (target - frames_done + 1) * FRAME_CYCLES;
		held = 1'b1;
		while (frames_done < target && waited < limit) begin
			@(negedge clk);
			waited++;
			if (frames_done < target && busy !== 1'b1) begin
				held = 1'b0;
			end
		end
		if (frames_done < target) begin
			$display("test %s: only %0d of %0d frames seen", cur_test, frames_done, target);
			errors++;
		end
		if (watch_busy) begin
			compare_level("busy held", 1'b1, held);
		end
	endtask

	task automatic wait_idle(input int limit);
		int waited;
		waited = 0;
		while (busy !== 1'b0 && waited < limit) begin
			@(negedge clk);
			waited++;
		end
		if (busy !== 1'b0) begin
			$display("test %s: busy did not fall within %0d cycles", cur_test, limit);
			errors++;
		end else if (exp_q.size() != 0) begin
			$display("test %s: %0d accepted bytes never left on tx", cur_test, exp_q.size());
			errors++;
		end
	endtask

	task automatic begin_test(input string name);
		cur_test = name;
		test_base = errors;
	endtask

	task automatic end_test();
		if (errors == test_base) begin
			tests_passed++;
			$display("test %s: ok", cur_test);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", cur_test, errors - test_base);
		end
	endtask

	// each bit sampled near its middle
	initial begin : line_sampler
		logic [FRAME_BITS-1:0] frame;
		data_t                 want;
		wait (reset == 1'b0);
		forever begin
			@(negedge tx);
			frames_started++;
			repeat (CLKS_PER_BIT / 2) @(negedge clk);
			for (int i = 0; i < FRAME_BITS; i++) begin
				if (i > 0) begin
					repeat (CLKS_PER_BIT) @(negedge clk);
				end
				frame[i] = tx;
			end
			if (frame[FRAME_BITS-1:DATA_BITS+1] !== '1) begin
				$display("test %s: stop bit missing after byte %h", cur_test,
					frame[DATA_BITS:1]);
				errors++;
			end
			if (exp_q.size() == 0) begin
				$display("test %s: frame on tx with no byte queued", cur_test);
				errors++;
			end else begin
				want = exp_q.pop_front();
				compare_byte("data", want, frame[DATA_BITS:1]);
				compare_frame("frame", expected_frame(want), frame);
			end
			frames_done++;
		end
	end

	initial begin : watchdog
		#(WATCHDOG_TIME);
		$display("watchdog expired before the tests finished");
		$display("sim failed");
		$finish;
	end

	initial begin : main_flow
		int base;
		clk = 1'b0;
		reset = 1'b1;
		start = 1'b0;
		data_in = '0;
		errors = 0;
		tests_passed = 0;
		tests_failed = 0;
		accepted = 0;
		frames_started = 0;
		frames_done = 0;
		seed = 32'h1978_5cd8;
		repeat (3) @(negedge clk);
		reset = 1'b0;

		begin_test("reset_idle");
		repeat (100) begin
			@(negedge clk);
			compare_level("tx", 1'b1, tx);
			compare_level("busy", 1'b0, busy);
			compare_level("full", 1'b0, full);
		end
		end_test();

		begin_test("single_byte");
		push_byte(8'hA5);
		compare_level("busy after push", 1'b1, busy);
		wait_frames(frames_done + 1, 1'b1);
		compare_level("busy in stop bit", 1'b1, busy);
		wait_idle(3 * CLKS_PER_BIT);
		repeat (2 * CLKS_PER_BIT + 2) begin
			@(negedge clk);
			compare_level("tx idle", 1'b1, tx);
			compare_level("busy idle", 1'b0, busy);
		end
		end_test();

		begin_test("held_start");
		base = frames_done;
		queue_byte(random_byte());
		repeat (200) @(negedge clk);
		start = 1'b0;
		wait_idle(2 * FRAME_CYCLES);
		repeat (2 * CLKS_PER_BIT) @(negedge clk);
		if (frames_done - base != 1) begin
			$display("Error %s frames: expected 1, actual %0d", cur_test, frames_done - base);
			errors++;
		end
		end_test();

		begin_test("burst_20");
		base = frames_done;
		for (int i = 0; i < BURST_BYTES; i++) begin
			push_byte(random_byte());
		end
		wait_frames(base + BURST_BYTES, 1'b1);
		wait_idle(2 * FRAME_CYCLES);
		end_test();

		begin_test("overflow_70");
		base = frames_started;
		for (int i = 0; i < FLOOD_BYTES; i++) begin
			push_byte(random_byte());
		end
		compare_level("full after flood", 1'b1, full);
		while (frames_started < base + 2) begin
			@(negedge clk);
		end
		compare_level("full after next frame", 1'b0, full);
		wait_frames(accepted, 1'b1);
		wait_idle(2 * FRAME_CYCLES);
		end_test();

		$display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
		if (errors == 0 && tests_failed == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+dv
rtl/uart_tx_pkg.sv
rtl/baud_tick_gen.sv
rtl/byte_fifo.sv
rtl/uart_tx_core.sv
rtl/uart_tx_top.sv
dv/uart_tx_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the UART transmit testbench with Verilator, run it, and judge the log.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log
TOP=uart_tx_tb

if ! command -v verilator > /dev/null 2>&1; then
	echo "verilator not found on PATH"
	exit 1
fi

verilator --binary --timing --assert -Wno-fatal \
	--top-module "$TOP" -Mdir "$BUILD_DIR" -f sim.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$BUILD_DIR/V$TOP" > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "sim passed" "$LOG_FILE"; then
	exit 0
fi

echo "pass message not found in $LOG_FILE"
exit 1
